// File: common/ddr_sched_macros.svh
// timing and width constants for the DDR3 refresh and command scheduler
// prescale, counter widths, need threshold and refresh busy time

`ifndef DDR_SCHED_MACROS_SVH
`define DDR_SCHED_MACROS_SVH

// ---------------------------------------------------------------------------
// refresh request side
// ---------------------------------------------------------------------------
`define DDR_REFRESH_PRESCALE 16  // clocks per refresh period tick
`define DDR_PENDING_W        5   // postponed refresh counter, up to 31
`define DDR_NEED_LEVEL       8   // pending count that makes refresh urgent

// ---------------------------------------------------------------------------
// command slot side
// ---------------------------------------------------------------------------
`define DDR_T_RFC            12  // slot busy clocks after a refresh command
`define DDR_USER_LEN_W       4   // user sequence length field

`endif

// File: common/ddr_cmd_pkg.sv
// command slot types
// issued command codes and arbiter FSM states

`default_nettype none

package ddr_cmd_pkg;

    // code that goes out with cmd_valid
    typedef enum logic [1:0] {
        CMD_NONE    = 2'd0,  // no command this cycle
        CMD_REFRESH = 2'd1,  // auto refresh
        CMD_USER    = 2'd2   // user sequence start
    } cmd_code_t;

    // command slot FSM
    typedef enum logic {
        ARB_IDLE = 1'b0,     // slot free, sampling requests
        ARB_BUSY = 1'b1      // counting down the current command
    } arb_state_t;

endpackage

`default_nettype wire

// File: common/ddr_refresh_pkg.sv
// refresh scheduling types
// period, postponed-count and user length types

`default_nettype none

`include "ddr_sched_macros.svh"

package ddr_refresh_pkg;

    // period in prescale ticks, 0 turns refresh off
    typedef logic [7:0] refresh_period_t;

    // postponed refreshes waiting for the slot
    typedef logic [`DDR_PENDING_W-1:0] pending_cnt_t;

    // user sequence length, slot busy for len + 1 clocks
    typedef logic [`DDR_USER_LEN_W-1:0] user_len_t;

endpackage

`default_nettype wire

// File: rtl/ddr_refresh.sv
// refresh request generator
// period timer in prescale ticks, postponed refresh counter,
// registered want (soft) and need (urgent) levels

`timescale 1ns/10ps
`default_nettype none

`include "ddr_sched_macros.svh"

module ddr_refresh
    import ddr_refresh_pkg::*;
(
    input  logic            rst,
    input  logic            clk,
    input  logic            en,              // live enable that gates want/need
    input  refresh_period_t refresh_period,  // 16-clock ticks where 0 is off
    input  logic            set,             // clears counters and latches enable
    input  logic            grant,           // one-cycle pulse from arbiter
    output logic            want,            // at least one refresh pending
    output logic            need             // backlog reached urgent level
);

    localparam int PRE_W = $clog2(`DDR_REFRESH_PRESCALE);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`DDR_REFRESH_PRESCALE - 1);
    localparam pending_cnt_t PENDING_MAX = '1;
    localparam pending_cnt_t NEED_LEVEL = pending_cnt_t'(`DDR_NEED_LEVEL);

    logic [PRE_W-1:0] pre_div;      // prescaler
    logic             cry;          // one tick every prescale period
    refresh_period_t  period_cnt;   // down counter in ticks
    logic             over;         // period underflow
    logic             refresh_due;  // registered underflow
    pending_cnt_t     pending_q;    // postponed refreshes
    logic             en_refresh;   // latched at set
    logic             en_r;         // en delayed one clock

    assign over = cry && (period_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en_r       <= 1'b0;
            en_refresh <= 1'b0;
        end else begin
            en_r <= en;
            if (set)
                en_refresh <= (refresh_period != '0);  // period 0 keeps refresh off
        end
    end

    // -----------------------------------------------------------------------
    // interval timer
    // -----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_div     <= '0;
            cry         <= 1'b0;
            period_cnt  <= '0;
            refresh_due <= 1'b0;
        end else begin
            if (set || !en_refresh)
                pre_div <= '0;                        // held while disabled
            else
                pre_div <= pre_div + 1'b1;
            cry <= !set && (pre_div == PRE_LAST);
            if (set)
                period_cnt <= '0;
            else if (over)
                period_cnt <= refresh_period;         // reload for period + 1 ticks
            else if (cry)
                period_cnt <= period_cnt - 1'b1;
            refresh_due <= over && !set;              // a due in the set cycle is dropped
        end
    end

    // -----------------------------------------------------------------------
    // backlog and request levels
    // -----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_q <= '0;
            want      <= 1'b0;
            need      <= 1'b0;
        end else begin
            if (set)
                pending_q <= '0;                      // drop backlog so nothing catches up
            else if (refresh_due && !grant && (pending_q != PENDING_MAX))
                pending_q <= pending_q + 1'b1;        // saturates at 31
            else if (!refresh_due && grant && (pending_q != '0))
                pending_q <= pending_q - 1'b1;
            want <= en_refresh && en_r && (pending_q != '0);
            need <= en_refresh && en_r && (pending_q >= NEED_LEVEL);
        end
    end

    // backlog saturates instead of rolling over to zero
    a_pending_no_wrap: assert property (@(posedge clk) disable iff (rst)
        (pending_q == PENDING_MAX && !set) |=> (pending_q != '0));

    // arbiter only grants a request it saw
    a_grant_after_want: assert property (@(posedge clk) disable iff (rst)
        grant |-> $past(want));

endmodule

`default_nettype wire

// File: rtl/ddr_cmd_arbiter.sv
// command slot arbiter
// fixed priority need > user > want, one-cycle command and grant,
// busy countdown for refresh (tRFC) and user (len + 1) commands

`timescale 1ns/10ps
`default_nettype none

`include "ddr_sched_macros.svh"

module ddr_cmd_arbiter
    import ddr_refresh_pkg::*;
    import ddr_cmd_pkg::*;
(
    input  logic      rst,
    input  logic      clk,
    input  logic      want,           // soft refresh request
    input  logic      need,           // urgent refresh request
    input  logic      user_rq,        // held until user_grant
    input  user_len_t user_len,       // stable while user_rq is high
    output logic      refresh_grant,  // one-cycle pulse to refresh block
    output logic      user_grant,     // one-cycle pulse to user side
    output logic      cmd_valid,      // command issued this cycle
    output cmd_code_t cmd_code        // CMD_NONE outside cmd_valid
);

    localparam int BUSY_W = `DDR_USER_LEN_W;

    typedef logic [BUSY_W-1:0] busy_cnt_t;

    // counter holds busy clocks minus one
    localparam busy_cnt_t REFRESH_BUSY_M1 = busy_cnt_t'(`DDR_T_RFC - 1);
    localparam busy_cnt_t MIN_BUSY_M1     = busy_cnt_t'(1);  // two clocks minimum

    arb_state_t state;
    busy_cnt_t  busy_cnt;
    busy_cnt_t  user_busy_m1;
    logic       pick_refresh;
    logic       pick_user;

    // -----------------------------------------------------------------------
    // winner selection, only used in idle
    // -----------------------------------------------------------------------
    always_comb begin
        pick_refresh = need || (want && !user_rq);   // urgent beats user, user beats soft
        pick_user    = user_rq && !need;
        // len + 1 busy clocks, but never under two so want can settle
        if (user_len == '0)
            user_busy_m1 = MIN_BUSY_M1;
        else
            user_busy_m1 = busy_cnt_t'(user_len);
    end

    // -----------------------------------------------------------------------
    // slot FSM
    // -----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= ARB_IDLE;
            busy_cnt      <= '0;
            cmd_valid     <= 1'b0;
            cmd_code      <= CMD_NONE;
            refresh_grant <= 1'b0;
            user_grant    <= 1'b0;
        end else begin
            cmd_valid     <= 1'b0;       // pulses by default
            cmd_code      <= CMD_NONE;
            refresh_grant <= 1'b0;
            user_grant    <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (pick_refresh) begin
                        state         <= ARB_BUSY;
                        busy_cnt      <= REFRESH_BUSY_M1;
                        cmd_valid     <= 1'b1;
                        cmd_code      <= CMD_REFRESH;
                        refresh_grant <= 1'b1;
                    end else if (pick_user) begin
                        state      <= ARB_BUSY;
                        busy_cnt   <= user_busy_m1;
                        cmd_valid  <= 1'b1;
                        cmd_code   <= CMD_USER;
                        user_grant <= 1'b1;
                    end
                end
                ARB_BUSY: begin
                    if (busy_cnt == '0)
                        state <= ARB_IDLE;          // free next clock
                    else
                        busy_cnt <= busy_cnt - 1'b1;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(refresh_grant && user_grant));

    // a command leaves only from a free slot
    a_cmd_from_idle: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> $past(state == ARB_IDLE));

    a_grant_with_cmd: assert property (@(posedge clk) disable iff (rst)
        (refresh_grant || user_grant) |-> cmd_valid);

endmodule

`default_nettype wire

// File: rtl/ddr_sched_top.sv
// scheduler top level
// refresh request block feeding the command slot arbiter,
// want/need brought out as status

`timescale 1ns/10ps
`default_nettype none

module ddr_sched_top
    import ddr_refresh_pkg::*;
    import ddr_cmd_pkg::*;
(
    input  logic            rst,
    input  logic            clk,
    input  logic            refresh_en,      // live refresh enable
    input  refresh_period_t refresh_period,  // 16-clock ticks, 0 = off
    input  logic            refresh_set,     // clear backlog, latch period
    input  logic            user_rq,         // user sequence request level
    input  user_len_t       user_len,        // user sequence length
    output logic            user_grant,      // one-cycle accept pulse
    output logic            cmd_valid,       // command issued
    output cmd_code_t       cmd_code,        // which command
    output logic            refresh_want,    // status, refresh pending
    output logic            refresh_need     // status, refresh urgent
);

    logic refresh_grant;  // arbiter back to refresh block

    ddr_refresh u_refresh (
        .rst            (rst),
        .clk            (clk),
        .en             (refresh_en),
        .refresh_period (refresh_period),
        .set            (refresh_set),
        .grant          (refresh_grant),
        .want           (refresh_want),
        .need           (refresh_need)
    );

    ddr_cmd_arbiter u_arbiter (
        .rst           (rst),
        .clk           (clk),
        .want          (refresh_want),
        .need          (refresh_need),
        .user_rq       (user_rq),
        .user_len      (user_len),
        .refresh_grant (refresh_grant),
        .user_grant    (user_grant),
        .cmd_valid     (cmd_valid),
        .cmd_code      (cmd_code)
    );

endmodule

`default_nettype wire

// File: sim/tb_ddr_sched.sv
// testbench for the DDR3 refresh and command scheduler
// reads scenarios from sim/ddr_sched_input.txt, drives user traffic,
// checks command spacing, priority, refresh intervals and counts

`timescale 1ns/10ps
`default_nettype none

`include "ddr_sched_macros.svh"

module tb_ddr_sched
    import ddr_refresh_pkg::*;
    import ddr_cmd_pkg::*;
();

    logic            rst;
    logic            clk;
    logic            refresh_en;
    refresh_period_t refresh_period;
    logic            refresh_set;
    logic            user_rq;
    user_len_t       user_len;
    logic            user_grant;
    logic            cmd_valid;
    cmd_code_t       cmd_code;
    logic            refresh_want;
    logic            refresh_need;

    logic [15:0] scen [0:63];   // period mode len window min max per scenario
    int seed = 3;
    int cyc, set_cyc, last_cmd_cyc, last_ref_cyc, last_len, cur_len, period_clk;
    int refresh_cnt, user_cnt, rq_wait;
    cmd_code_t last_code;
    bit need_armed, need_seen, want_seen, check_interval;

    ddr_sched_top UUT (
        .rst(rst), .clk(clk), .refresh_en(refresh_en), .refresh_period(refresh_period),
        .refresh_set(refresh_set), .user_rq(user_rq), .user_len(user_len),
        .user_grant(user_grant), .cmd_valid(cmd_valid), .cmd_code(cmd_code),
        .refresh_want(refresh_want), .refresh_need(refresh_need)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period

    task automatic check_equal(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("error at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    endtask

    // ------------------------------------------------------------------------
    // one clock of sampling at the falling edge and checking the command stream
    // ------------------------------------------------------------------------
    task automatic step();
        @(negedge clk);
        cyc++;
        if (refresh_want)
            want_seen = 1'b1;
        if (cmd_valid) begin
            if (last_code == CMD_USER)   // user slot is len + 1 busy clocks
                check_equal(int'(cyc - last_cmd_cyc >= last_len + 2), 1, "user busy too short");
            if (last_code == CMD_REFRESH)
                check_equal(int'(cyc - last_cmd_cyc >= `DDR_T_RFC + 1), 1, "tRFC too short");
            if (need_armed)   // urgent refresh beats user
                check_equal(int'(cmd_code), int'(CMD_REFRESH), "need did not win the slot");
            check_equal(int'(user_grant), int'(cmd_code == CMD_USER), "user_grant vs cmd_code");
            if (cmd_code == CMD_REFRESH) begin
                refresh_cnt++;
                if (check_interval && last_ref_cyc >= 0)
                    check_equal(cyc - last_ref_cyc, period_clk, "refresh interval");
                last_ref_cyc = cyc;
            end else begin
                user_cnt++;
            end
            last_cmd_cyc = cyc;
            last_code    = cmd_code;
            last_len     = cur_len;
            need_armed   = 1'b0;
        end else begin
            check_equal(int'(user_grant), 0, "user_grant without cmd_valid");
            check_equal(int'(cmd_code), int'(CMD_NONE), "cmd_code outside cmd_valid");
            need_armed = refresh_need && (cyc - last_cmd_cyc >= 3);  // settled after grant
        end
    endtask

    // mode 0 none, 1 sparse, 2 back-to-back
    task automatic run_window(input int n, input int mode);
        for (int i = 0; i < n; i++) begin
            step();
            if (user_rq && user_grant && mode != 2)
                user_rq = 1'b0;
            if (mode == 2)
                user_rq = 1'b1;
            else if (mode == 1 && !user_rq && (($random(seed) & 15) == 0)) begin
                user_rq = 1'b1;
                rq_wait = 0;
            end
            if (user_rq && mode == 1) begin
                rq_wait++;
                if (rq_wait > 64)
                    report_timeout("sparse user request never granted");
            end
            if (refresh_en && refresh_period != 0 && cyc - last_cmd_cyc > period_clk + 40
                    && cyc - set_cyc > period_clk + 40)
                report_timeout("no command issued while refresh is running");
            if (refresh_need && !need_seen) begin
                need_seen = 1'b1;
                check_equal(int'(cyc - set_cyc >= 16 + 7 * period_clk), 1, "need too early");
                if (mode == 2)
                    check_equal(refresh_cnt, 0, "refresh before need under user load");
            end
        end
    endtask

    // drain user side, quiet the refresh block, then pulse set
    task automatic start_scenario(input int p, input int len);
        rq_wait = 0;
        while (user_rq) begin
            step();
            rq_wait++;
            if (user_grant)
                user_rq = 1'b0;
            else if (rq_wait > 64)
                report_timeout("user request not granted before set");
        end
        refresh_en = 1'b0;
        for (int i = 0; i < 8; i++)
            step();
        refresh_period = refresh_period_t'(p);
        user_len       = user_len_t'(len);
        cur_len        = len;
        period_clk     = `DDR_REFRESH_PRESCALE * (p + 1);
        refresh_en     = 1'b1;
        refresh_set    = 1'b1;
        set_cyc        = cyc;
        step();
        refresh_set  = 1'b0;
        refresh_cnt  = 0;
        user_cnt     = 0;
        last_ref_cyc = -1;
        need_armed   = 1'b0;
        need_seen    = 1'b0;
        want_seen    = 1'b0;
    endtask

    initial begin
        int k, p, mode, len, win, mn, mx, r0, u0;
        rst = 1'b1;
        refresh_en = 1'b1;                    // refresh stays off until the first set
        refresh_period = refresh_period_t'(1);
        refresh_set = 1'b0;
        user_rq = 1'b0;
        user_len = '0;
        cyc = 0;
        last_cmd_cyc = -1000;
        last_code = CMD_NONE;
        $readmemh("sim/ddr_sched_input.txt", scen);
        repeat (2) @(negedge clk);   // reset for two cycles
        rst = 1'b0;
        for (int i = 0; i < 64; i++) begin   // quiet before any set
            step();
            check_equal(int'(cmd_valid), 0, "cmd_valid before set");
            check_equal(int'(refresh_want || refresh_need), 0, "refresh status before set");
        end
        k = 0;
        while (k < 10 && scen[k * 6] != 16'hffff) begin
            p    = scen[k * 6];
            mode = scen[k * 6 + 1];
            len  = scen[k * 6 + 2];
            win  = scen[k * 6 + 3];
            mn   = scen[k * 6 + 4];
            mx   = scen[k * 6 + 5];
            start_scenario(p, len);
            check_interval = (mode == 0);
            run_window(win, (mode == 3) ? 2 : mode);
            check_interval = 1'b0;
            if (refresh_cnt < mn)
                check_equal(refresh_cnt, mn, "too few refresh commands");
            if (refresh_cnt > mx)
                check_equal(refresh_cnt, mx, "too many refresh commands");
            if (p == 0)
                check_equal(int'(want_seen), 0, "refresh_want with refresh off");
            if (mode != 0)
                check_equal(int'(user_cnt > 0), 1, "no user command issued");
            if (mode == 3) begin
                refresh_en = 1'b0;   // in-flight refresh may still land
                run_window(3, 2);
                r0 = refresh_cnt;
                u0 = user_cnt;
                run_window(win, 2);
                check_equal(refresh_cnt, r0, "refresh while disabled");
                check_equal(int'(user_cnt > u0), 1, "user traffic stopped while disabled");
                refresh_en  = 1'b1;
                refresh_set = 1'b1;  // clears the backlog
                set_cyc     = cyc;
                need_seen   = 1'b0;
                step();
                refresh_set = 1'b0;
                for (int i = 0; i < 14; i++) begin
                    step();
                    check_equal(int'(refresh_want), 0, "want after set with backlog");
                end
                run_window(7 * period_clk, 2);
                check_equal(refresh_cnt, r0, "catch-up refresh burst after set");
            end
            k++;
        end
        if (scen[k * 6] !== 16'hffff) begin
            $display("scenario file sim/ddr_sched_input.txt missing or without end marker");
            $display("*** TEST FAILED ***");
            $fatal(1, "bad input file");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim/ddr_sched_input.txt
// period mode len window min max, all hex
// mode 0 none, 1 sparse, 2 back-to-back, 3 back-to-back with enable drop and set
0000 0000 0000 0190 0000 0000
0001 0000 0000 0258 0012 0013
0003 0000 0000 0320 000c 000d
0001 0001 0003 0320 0017 0019
0001 0002 0005 04b0 001b 0020
0002 0002 0009 0600 0015 001a
0001 0003 0004 0258 0008 000d
ffff

// File: verilog.f
+incdir+common
common/ddr_cmd_pkg.sv
common/ddr_refresh_pkg.sv
rtl/ddr_refresh.sv
rtl/ddr_cmd_arbiter.sv
rtl/ddr_sched_top.sv
sim/tb_ddr_sched.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_ddr_sched -o sim_ddr_sched

if ! out="$(./obj_dir/sim_ddr_sched 2>&1)"; then
    echo "$out"
    exit 1
fi
echo "$out"
if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1
